// ==== bench/snd_cases.txt ====
# kind addr data fm_left fm_right enables expected, all hex
# enables bit 1 is FM, bit 0 is ADPCM; play/stop use addr=phrase, data=bytes, expected=rate
romaddr 1234 00 0000 0000 0 1234
romaddr 8123 00 0000 0000 0 8123
read 1234 00 0000 0000 0 0034
read 8155 00 0000 0000 0 0055
write F004 01 0000 0000 0 0000
romaddr 8123 00 0000 0000 0 C123
romaddr 0456 00 0000 0000 0 0456
read 9A77 00 0000 0000 0 0077
write D123 A5 0000 0000 0 0000
read D123 00 0000 0000 0 00A5
write D7FF 3C 0000 0000 0 0000
read DFFF 00 0000 0000 0 003C
read F008 00 0000 0000 0 00C3
read F00A 00 0000 0000 0 0096
read F00C 00 0000 0000 0 00FF
read F002 00 0000 0000 0 0000
fmwr F000 12 0000 0000 0 0006
fmwr F001 34 0000 0000 0 0007
read F000 00 0000 0000 0 005A
mix 0000 00 1234 8002 3 091A
mix 0000 00 1234 8002 2 091A
mix 0000 00 1234 8002 1 0000
mix 0000 00 FFFF 7FFF 2 FFFF
write F006 01 0000 0000 0 0000
play 0003 04 0000 0000 1 0084
write F006 00 0000 0000 0 0000
play 0005 03 0000 0000 1 00A5
stop 0007 28 0000 0000 1 00A5

// ==== compile.f ====
logic/snd_pkg.sv
logic/snd_frac_cen.sv
logic/snd_ram.sv
logic/snd_addr_decode.sv
logic/snd_din_mux.sv
logic/snd_adpcm.sv
logic/snd_board.sv
bench/snd_board_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= snd_board_tb
RTL_TOP   ?= snd_board
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/snd_board_tb.sv ====
/* Testbench for the sound board, driven by bench/snd_cases.txt.
   Run from the project root so the case file path resolves.
   ROM model returns the low address byte; ADPCM ROM answers after a random delay. */
module snd_board_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import snd_pkg::*;

    localparam integer SAMPLE_LIMIT = 170 * 48 + 100;   // Clocks, slowest rate plus margin
    localparam integer MAX_BYTES    = 8;
    localparam longint PHRASE_NS    = longint'(2 * MAX_BYTES + 4) * 165 * 48 * 100;

    logic clk;
    logic rst;
    cpu_bus_t bus;
    logic [7:0] din;
    logic [7:0] snd_latch0;
    logic [7:0] snd_latch1;
    logic enable_fm;
    logic enable_adpcm;
    logic [15:0] rom_addr;
    logic rom_cs;
    logic [7:0] rom_data;
    logic [17:0] adpcm_addr;
    logic adpcm_cs;
    logic [7:0] adpcm_data;
    logic adpcm_ok;
    logic cpu_cen;
    logic fm_cen;
    logic fm_cen2;
    logic fm_cs;
    logic fm_wr;
    logic fm_a0;
    logic [7:0] fm_din;
    logic signed [15:0] fm_left;
    logic signed [15:0] fm_right;
    logic signed [15:0] left;
    logic signed [15:0] right;

    logic [7:0] adpcm_rom [262144];
    integer step_tab [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73, 80,
        88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307, 337,
        371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282,
        1411, 1552
    };

    string  kinds [$];
    logic [15:0] c_addr [$];
    logic [7:0]  c_data [$];
    logic [15:0] c_fml [$];
    logic [15:0] c_fmr [$];
    logic [1:0]  c_en [$];
    logic [15:0] c_exp [$];
    integer errors = 0;
    integer failed_tests = 0;
    integer seed = 32'h5e82_6357;
    integer fetch_wait = -1;
    logic   loaded = 1'b0;

    logic   cpu_cen_q = 1'b0;
    logic   rst_q = 1'b1;
    logic   half_q = 1'b0;
    logic   half_valid = 1'b0;
    integer cen_clocks = 0;
    integer cen_pulses = 0;

    snd_board uut (.*);

    assign rom_data = rom_addr[7:0];   // Program ROM model

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ADPCM ROM model, answers each fetch after a random number of clocks
    always @(negedge clk) begin
        if (rst || !adpcm_cs) begin
            adpcm_ok = 1'b0;
            fetch_wait = -1;
        end else if (adpcm_ok) begin
            note_fault("adpcm_rom", "adpcm_cs stayed high after adpcm_ok");
            adpcm_ok = 1'b0;
        end else begin
            if (fetch_wait < 0) fetch_wait = $random(seed) & 15;
            if (fetch_wait == 0) begin
                adpcm_data = adpcm_rom[adpcm_addr];
                adpcm_ok = 1'b1;
                fetch_wait = -1;
            end else begin
                fetch_wait = fetch_wait - 1;
            end
        end
    end

    // FM enables trail cpu_cen by 1 clock, 3 cpu_cen pulses in any 40 clocks
    always @(negedge clk) begin
        if (!rst && !rst_q) begin
            check("fm_cen", {31'd0, cpu_cen_q}, {31'd0, fm_cen});
            if (fm_cen2 && !fm_cen) begin
                note_fault("fm_cen2", "fm_cen2 pulsed without fm_cen");
            end
            if (fm_cen) begin
                if (half_valid && fm_cen2 === half_q) begin
                    note_fault("fm_cen2", "fm_cen2 is not on every second fm_cen pulse");
                end
                half_q = fm_cen2;
                half_valid = 1'b1;
            end
            cen_pulses = cen_pulses + (cpu_cen ? 1 : 0);
            cen_clocks = cen_clocks + 1;
            if (cen_clocks == 40) begin
                check("cpu_cen_rate", 32'd3, cen_pulses);
                cen_clocks = 0;
                cen_pulses = 0;
            end
        end
        cpu_cen_q = cpu_cen;
        rst_q = rst;
    end

    function automatic logic [7:0] fill_byte(input logic [17:0] a);
        logic [7:0] v;
        v = (a[7:0] * 8'd37) ^ a[15:8] ^ {6'd0, a[17:16]};
        v = v & 8'hBF;   // Keeps the high nibble index falling
        if (v == 8'h80) v = 8'h81;
        return v;
    endfunction

    function automatic logic [15:0] mix_rule(input logic signed [15:0] fm, input logic [1:0] en,
                                             input integer snd);
        integer f;
        integer a;
        f = en[1] ? integer'($signed(fm) >>> 1) : 0;
        a = en[0] ? snd * 2 : 0;
        return 16'(f + a);
    endfunction

    task automatic adpcm_model(input logic [3:0] nib, inout integer pred, inout integer idx);
        integer step;
        integer mag;
        step = step_tab[idx];
        mag = step >> 3;
        if (nib[0]) mag = mag + (step >> 2);
        if (nib[1]) mag = mag + (step >> 1);
        if (nib[2]) mag = mag + step;
        pred = nib[3] ? pred - mag : pred + mag;
        if (pred > 2047) pred = 2047;
        if (pred < -2048) pred = -2048;
        idx = nib[2] ? idx + (integer'(nib[1:0]) + 1) * 2 : idx - 1;
        if (idx < 0) idx = 0;
        if (idx > 48) idx = 48;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error in %s: expected %h, actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic note_fault(input string name, input string what);
        $display("%s: %s", name, what);
        errors = errors + 1;
    endtask

    task automatic bus_idle();
        bus = '{addr: 16'h0000, dout: 8'h00, mreq: 1'b0, wr: 1'b0};
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk);
        bus = '{addr: addr, dout: data, mreq: 1'b1, wr: 1'b1};
        repeat (2) @(negedge clk);   // Selects register, then the write lands
        bus_idle();
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(negedge clk);
        bus = '{addr: addr, dout: 8'h00, mreq: 1'b1, wr: 1'b0};
        repeat (3) @(negedge clk);
        data = din;
        bus_idle();
    endtask

    task automatic wait_sample(input logic [15:0] prev, output logic ok, output integer clocks);
        clocks = 0;
        ok = 1'b0;
        while (!ok && clocks < SAMPLE_LIMIT) begin
            @(negedge clk);
            clocks = clocks + 1;
            if (left !== prev) ok = 1'b1;
        end
    endtask

    task automatic play_phrase(input string name, input logic [6:0] phrase, input integer len,
                               input integer rate, input logic stop_early);
        logic [17:0] base;
        logic [7:0]  b;
        logic [7:0]  st;
        logic [15:0] prev;
        logic [15:0] e16;
        logic        ok;
        integer      pred;
        integer      idx;
        integer      gap;
        integer      tries;
        integer      n;
        base = {phrase, 11'd0};
        adpcm_rom[base + 18'(len)] = ADPCM_STOP_BYTE;
        pred = 0;
        idx = 0;
        prev = 16'd0;
        ok = 1'b1;
        @(negedge clk);
        enable_fm = 1'b0;
        enable_adpcm = 1'b1;
        bus_write(IO_PAGE << 12 | 16'h0002, {1'b1, phrase});
        check(name, {14'd0, base}, {14'd0, adpcm_addr});
        check(name, 32'd1, {31'd0, adpcm_cs});   // First byte fetch under way
        bus_read(16'hF002, st);
        check(name, 32'd1, {31'd0, st[0]});
        n = stop_early ? 2 : 2 * len;
        for (int s = 0; s < n && ok; s++) begin
            b = adpcm_rom[base + 18'(s / 2)];
            adpcm_model(s % 2 == 0 ? b[7:4] : b[3:0], pred, idx);
            wait_sample(prev, ok, gap);
            if (!ok) begin
                note_fault(name, "no ADPCM sample arrived in time");
            end else begin
                e16 = 16'(pred * 8);
                check(name, {16'd0, e16}, {16'd0, left});
                if (s == 1) check(name, rate, gap / 48);
                prev = left;
            end
        end
        if (stop_early) bus_write(16'hF002, 8'h00);
        tries = 0;
        st = 8'h01;
        while (st[0] && tries < 1000) begin
            bus_read(16'hF002, st);
            tries = tries + 1;
        end
        if (st[0]) note_fault(name, "playback never stopped");
        check(name, 32'd0, {16'd0, left});
        check(name, 32'd0, {31'd0, adpcm_cs});
    endtask

    initial begin
        integer fd;
        string  line;
        string  k;
        integer a;
        integer d;
        integer fl;
        integer fr;
        integer en;
        integer ex;
        integer errs_before;
        logic [7:0] rd;
        string  name;
        rst = 1'b1;
        bus_idle();
        snd_latch0 = 8'hC3;
        snd_latch1 = 8'h96;
        enable_fm = 1'b0;
        enable_adpcm = 1'b0;
        adpcm_data = 8'h00;
        adpcm_ok = 1'b0;
        fm_din = 8'h5A;
        fm_left = 16'sd0;
        fm_right = 16'sd0;
        for (int i = 0; i < 262144; i++) adpcm_rom[i] = fill_byte(18'(i));
        fd = $fopen("bench/snd_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file bench/snd_cases.txt");
            $display("Something failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h %h %h", k, a, d, fl, fr, en, ex) == 7) begin
                        kinds.push_back(k);
                        c_addr.push_back(16'(a));
                        c_data.push_back(8'(d));
                        c_fml.push_back(16'(fl));
                        c_fmr.push_back(16'(fr));
                        c_en.push_back(2'(en));
                        c_exp.push_back(16'(ex));
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (8) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (kinds[i]) begin
                name = $sformatf("%0d_%0s", i, kinds[i]);
                errs_before = errors;
                if (kinds[i] == "romaddr") begin
                    @(negedge clk);
                    bus = '{addr: c_addr[i], dout: 8'h00, mreq: 1'b1, wr: 1'b0};
                    @(negedge clk);
                    check(name, {16'd0, c_exp[i]}, {16'd0, rom_addr});
                    check(name, 32'd1, {31'd0, rom_cs});
                    bus_idle();
                end else if (kinds[i] == "read") begin
                    bus_read(c_addr[i], rd);
                    check(name, {16'd0, c_exp[i]}, {24'd0, rd});
                end else if (kinds[i] == "write") begin
                    bus_write(c_addr[i], c_data[i]);
                end else if (kinds[i] == "fmwr") begin
                    @(negedge clk);
                    bus = '{addr: c_addr[i], dout: c_data[i], mreq: 1'b1, wr: 1'b1};
                    @(negedge clk);
                    check(name, {16'd0, c_exp[i]}, {29'd0, fm_cs, fm_wr, fm_a0});
                    @(negedge clk);
                    bus_idle();
                end else if (kinds[i] == "mix") begin
                    @(negedge clk);
                    fm_left = c_fml[i];
                    fm_right = c_fmr[i];
                    enable_fm = c_en[i][1];
                    enable_adpcm = c_en[i][0];
                    @(negedge clk);   // ADPCM is idle, so its sample is 0
                    check(name, {16'd0, c_exp[i]}, {16'd0, left});
                    check(name, {16'd0, mix_rule(c_fmr[i], c_en[i], 0)}, {16'd0, right});
                end else if (kinds[i] == "play" || kinds[i] == "stop") begin
                    play_phrase(name, c_addr[i][6:0], integer'(c_data[i]),
                                integer'(c_exp[i]), kinds[i] == "stop");
                end else begin
                    note_fault(name, "unknown test kind in the case file");
                end
                if (errors != errs_before) failed_tests = failed_tests + 1;
                $display("%s %s", name, errors == errs_before ? "passed" : "failed");
            end
            $display("Tests run %0d, failed %0d, errors %0d", kinds.size(), failed_tests, errors);
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of cases
    initial begin
        wait (loaded);
        #(longint'(kinds.size()) * PHRASE_NS);
        $display("Watchdog expired before all tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== logic/snd_board.sv ====
/* Sound board without its CPU core and FM chip, both connect through ports.
   Assumes a 48 MHz clk. FM enables lag cpu_cen by 1 clock.
   The mixer sum is not saturated. */
module snd_board (
    input  logic               rst,
    input  logic               clk,
    input  snd_pkg::cpu_bus_t  bus,
    output logic [7:0]         din,
    input  logic [7:0]         snd_latch0,
    input  logic [7:0]         snd_latch1,
    input  logic               enable_fm,
    input  logic               enable_adpcm,
    output logic [15:0]        rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    output logic [17:0]        adpcm_addr,
    output logic               adpcm_cs,
    input  logic [7:0]         adpcm_data,
    input  logic               adpcm_ok,
    output logic               cpu_cen,
    output logic               fm_cen,
    output logic               fm_cen2,
    output logic               fm_cs,
    output logic               fm_wr,
    output logic               fm_a0,
    input  logic [7:0]         fm_din,
    input  logic signed [15:0] fm_left,
    input  logic signed [15:0] fm_right,
    output logic signed [15:0] left,
    output logic signed [15:0] right
);
    import snd_pkg::*;

    dev_sel_t           sel;
    logic [1:0]         fm_pre;
    logic [1:0]         oki_cen;   // Only full rate is used
    logic               oki_ss;
    logic               wr_q;
    logic [7:0]         ram_q;
    logic [7:0]         oki_dout;
    logic signed [13:0] adpcm_snd;

    function automatic logic signed [15:0] mix(
        input logic               en_fm,
        input logic               en_adpcm,
        input logic signed [15:0] fm,
        input logic signed [13:0] adpcm
    );
        logic signed [15:0] fm_part;
        logic signed [15:0] adpcm_part;
        fm_part    = en_fm ? {fm[15], fm[15:1]} : 16'sd0;
        adpcm_part = en_adpcm ? {adpcm[13], adpcm, 1'b0} : 16'sd0;
        return fm_part + adpcm_part;
    endfunction

    snd_frac_cen #(.n(FM_CEN_N), .m(FM_CEN_M)) u_fm_cen (
        .clk (clk),
        .cen (fm_pre)
    );

    snd_frac_cen #(.n(OKI_CEN_N), .m(OKI_CEN_M)) u_oki_cen (
        .clk (clk),
        .cen (oki_cen)
    );

    assign cpu_cen = fm_pre[0];

    // FM chip sees its enable one clock after the CPU
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fm_cen  <= 1'b0;
            fm_cen2 <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            fm_cen  <= fm_pre[0];
            fm_cen2 <= fm_pre[1];
            wr_q    <= bus.mreq & bus.wr;   // Lines up with the selects
        end
    end

    always_ff @(posedge clk) begin
        fm_a0 <= bus.addr[0];
    end

    assign fm_cs = sel.fm;
    assign fm_wr = sel.fm & wr_q;

    snd_addr_decode u_decode (
        .rst      (rst),
        .clk      (clk),
        .bus      (bus),
        .sel      (sel),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .oki_ss   (oki_ss)
    );

    snd_ram u_ram (
        .clk  (clk),
        .addr (bus.addr[10:0]),
        .din  (bus.dout),
        .we   (sel.ram & bus.wr),
        .q    (ram_q)
    );

    snd_din_mux u_din_mux (
        .clk      (clk),
        .sel      (sel),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .ram_q    (ram_q),
        .fm_din   (fm_din),
        .oki_dout (oki_dout),
        .latch0   (snd_latch0),
        .latch1   (snd_latch1),
        .din      (din)
    );

    snd_adpcm u_adpcm (
        .rst       (rst),
        .clk       (clk),
        .cen       (oki_cen[0]),
        .ss        (oki_ss),
        .wr_strobe (sel.oki & bus.wr),
        .wdata     (bus.dout),
        .status    (oki_dout),
        .rom_addr  (adpcm_addr),
        .rom_cs    (adpcm_cs),
        .rom_data  (adpcm_data),
        .rom_ok    (adpcm_ok),
        .sound     (adpcm_snd)
    );

    always_ff @(posedge clk) begin
        left  <= mix(enable_fm, enable_adpcm, fm_left, adpcm_snd);
        right <= mix(enable_fm, enable_adpcm, fm_right, adpcm_snd);
    end

endmodule

// ==== logic/snd_adpcm.sv ====
/* Single-voice 4-bit ADPCM phrase player.
   Phrases start at phrase * 2048 and end on the stop byte or a stop command.
   A fetch still pending when a sample is due stalls the voice.
   No volume and no phrase header table. */
module snd_adpcm (
    input  logic               rst,
    input  logic               clk,
    input  logic               cen,
    input  logic               ss,
    input  logic               wr_strobe,
    input  logic [7:0]         wdata,
    output logic [7:0]         status,
    output logic [17:0]        rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output logic signed [13:0] sound
);
    import snd_pkg::*;

    adpcm_cmd_u         cmd;
    logic               wr_last;
    logic               wr_edge;
    logic               playing;
    logic               pending;    // ROM fetch in flight
    logic               hi_nib;
    logic               sample_go;
    logic [7:0]         cur_byte;
    logic [7:0]         div_cnt;
    logic [7:0]         div_end;
    logic [5:0]         step_idx;
    logic signed [11:0] pred;
    logic [3:0]         nib;
    logic [10:0]        step;
    logic [11:0]        mag;
    logic signed [13:0] sum;
    logic signed [11:0] pred_next;
    logic signed [7:0]  idx_sum;
    logic [5:0]         idx_next;

    assign cmd       = wdata;
    assign wr_edge   = wr_strobe && !wr_last;   // One action per bus write
    assign div_end   = ss ? ADPCM_DIV_FAST - 8'd1 : ADPCM_DIV_SLOW - 8'd1;
    assign sample_go = playing && cen && div_cnt >= div_end && !pending;
    assign status    = {7'd0, playing};
    assign rom_cs    = pending;

    always_comb begin
        nib  = hi_nib ? cur_byte[7:4] : cur_byte[3:0];
        step = STEP_TABLE[step_idx];
        mag  = {4'd0, step[10:3]};
        if (nib[0]) mag = mag + {3'd0, step[10:2]};
        if (nib[1]) mag = mag + {2'd0, step[10:1]};
        if (nib[2]) mag = mag + {1'b0, step};
        sum = {{2{pred[11]}}, pred};
        if (nib[3]) begin
            sum = sum - $signed({2'b00, mag});   // Sign bit
        end else begin
            sum = sum + $signed({2'b00, mag});
        end
        // Clamp to 12 bits
        if (sum > 14'sd2047) begin
            pred_next = 12'sd2047;
        end else if (sum < -14'sd2048) begin
            pred_next = -12'sd2048;
        end else begin
            pred_next = sum[11:0];
        end
        idx_sum = $signed({2'b00, step_idx}) + 8'(INDEX_ADJ[nib[2:0]]);
        if (idx_sum < 8'sd0) begin
            idx_next = 6'd0;
        end else if (idx_sum > 8'sd48) begin
            idx_next = 6'd48;
        end else begin
            idx_next = idx_sum[5:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_last  <= 1'b0;
            playing  <= 1'b0;
            pending  <= 1'b0;
            hi_nib   <= 1'b1;
            div_cnt  <= '0;
            step_idx <= '0;
            pred     <= '0;
            sound    <= '0;
        end else begin
            wr_last <= wr_strobe;
            if (wr_edge) begin
                if (cmd.play.start) begin
                    playing  <= 1'b1;
                    pending  <= 1'b1;   // First byte fetch
                    hi_nib   <= 1'b1;
                    div_cnt  <= '0;
                    step_idx <= '0;
                    pred     <= '0;
                end else if (!cmd.stop.zero) begin
                    playing <= 1'b0;
                    pending <= 1'b0;
                    sound   <= '0;
                end
            end else if (playing) begin
                if (pending && rom_ok) begin
                    pending <= 1'b0;
                    if (rom_data == ADPCM_STOP_BYTE) begin
                        playing <= 1'b0;   // End of phrase
                        sound   <= '0;
                    end
                end
                if (cen && div_cnt < div_end) begin
                    div_cnt <= div_cnt + 8'd1;
                end
                if (sample_go) begin
                    div_cnt  <= '0;
                    pred     <= pred_next;
                    step_idx <= idx_next;
                    sound    <= {pred_next, 2'b00};
                    hi_nib   <= !hi_nib;
                    if (!hi_nib) begin
                        pending <= 1'b1;   // Low nibble done, next byte
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_edge && cmd.play.start) begin
            rom_addr <= {cmd.play.phrase, 11'd0};
        end else if (sample_go && !hi_nib) begin
            rom_addr <= rom_addr + 18'd1;
        end
        if (pending && rom_ok) begin
            cur_byte <= rom_data;
        end
    end

endmodule

// ==== logic/snd_din_mux.sv ====
/* Read-data mux in two registered stages.
   Data is valid 2 clocks after the selects, 3 after the bus.
   Priority is device, then latch, then memory, else 0xFF. */
module snd_din_mux (
    input  logic              clk,
    input  snd_pkg::dev_sel_t sel,
    input  logic              rom_cs,
    input  logic [7:0]        rom_data,
    input  logic [7:0]        ram_q,
    input  logic [7:0]        fm_din,
    input  logic [7:0]        oki_dout,
    input  logic [7:0]        latch0,
    input  logic [7:0]        latch1,
    output logic [7:0]        din
);

    logic [7:0] dev_q;
    logic [7:0] lat_q;
    logic [7:0] mem_q;
    logic       dev_v;
    logic       lat_v;
    logic       mem_v;

    // Stage 1, one candidate per group
    always_ff @(posedge clk) begin
        dev_q <= sel.fm ? fm_din : oki_dout;
        dev_v <= sel.fm | sel.oki;
        lat_q <= sel.latch0 ? latch0 : latch1;
        lat_v <= sel.latch0 | sel.latch1;
        mem_q <= sel.ram ? ram_q : rom_data;
        mem_v <= sel.ram | rom_cs;
    end

    // Stage 2, fixed priority
    always_ff @(posedge clk) begin
        if (dev_v) begin
            din <= dev_q;
        end else if (lat_v) begin
            din <= lat_q;
        end else if (mem_v) begin
            din <= mem_q;
        end else begin
            din <= 8'hFF;   // Open bus
        end
    end

endmodule

// ==== logic/snd_addr_decode.sv ====
/* Address decoder for the sound CPU bus.
   Selects and ROM address are registered, valid 1 clock after the bus.
   Bank and rate registers take bit 0 of the write data. */
module snd_addr_decode (
    input  logic               rst,
    input  logic               clk,
    input  snd_pkg::cpu_bus_t  bus,
    output snd_pkg::dev_sel_t  sel,
    output logic               rom_cs,
    output logic [15:0]        rom_addr,
    output logic               oki_ss
);
    import snd_pkg::*;

    dev_sel_t sel_d;
    logic     io_cs;
    logic     rom_hit;
    logic     bank;
    logic     oki7;

    assign io_cs   = bus.mreq && bus.addr[15:12] == IO_PAGE;
    // Below 0x8000 or the 16 KB banked window
    assign rom_hit = bus.mreq && (!bus.addr[15] || bus.addr[15:14] == 2'b10);

    always_comb begin
        sel_d        = '0;
        sel_d.rom    = rom_hit;
        sel_d.ram    = bus.mreq && bus.addr[15:12] == RAM_PAGE;
        sel_d.fm     = io_cs && bus.addr[3:1] == 3'd0;
        sel_d.oki    = io_cs && bus.addr[3:1] == 3'd1;
        sel_d.bank   = io_cs && bus.addr[3:1] == 3'd2;
        sel_d.oki7   = io_cs && bus.addr[3:1] == 3'd3;
        sel_d.latch0 = io_cs && bus.addr[3:1] == 3'd4;
        sel_d.latch1 = io_cs && bus.addr[3:1] == 3'd5;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel <= sel_d;
        end
    end

    assign rom_cs = sel.rom;   // Registered ROM select

    always_ff @(posedge clk) begin
        if (bus.addr[15]) begin
            rom_addr <= {1'b1, bank, bus.addr[13:0]};   // Banked window
        end else begin
            rom_addr <= {1'b0, bus.addr[14:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            oki7 <= 1'b0;
        end else begin
            if (sel.bank && bus.wr) begin
                bank <= bus.dout[0];
            end
            if (sel.oki7 && bus.wr) begin
                oki7 <= bus.dout[0];
            end
        end
    end

    assign oki_ss = oki7;   // 1 selects the faster sample rate

endmodule

// ==== logic/snd_ram.sv ====
/* 2 KB work RAM, single port.
   Read data is registered, so q follows addr one clock later. */
module snd_ram (
    input  logic        clk,
    input  logic [10:0] addr,
    input  logic [7:0]  din,
    input  logic        we,
    output logic [7:0]  q
);

    logic [7:0] mem [2048];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        q <= mem[addr];   // Old data on a write clock
    end

endmodule

// ==== logic/snd_frac_cen.sv ====
/* Fractional clock enable, n pulses every m clocks.
   Needs n <= m. Bit 1 of cen fires on every second bit 0 pulse.
   No reset, the accumulator starts from its power-up value. */
module snd_frac_cen #(
    parameter logic [9:0] n = 10'd1,
    parameter logic [9:0] m = 10'd48
) (
    input  logic       clk,
    output logic [1:0] cen = 2'b00
);

    logic [10:0] acc = '0;
    logic [10:0] acc_sum;
    logic        half = 1'b0;   // Toggles on each full-rate pulse

    assign acc_sum = acc + {1'b0, n};

    always_ff @(posedge clk) begin
        if (acc_sum >= {1'b0, m}) begin
            acc  <= acc_sum - {1'b0, m};   // Wrap, keep the remainder
            cen  <= {half, 1'b1};
            half <= ~half;
        end else begin
            acc <= acc_sum;
            cen <= 2'b00;
        end
    end

endmodule

// ==== logic/snd_pkg.sv ====
/* Shared types and constants for the sound board.
   Bus levels are active high. Clock-enable ratios assume a 48 MHz clk.
   The step table covers the 49 steps of the 4-bit ADPCM chip. */
package snd_pkg;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;   // Write data from the CPU
        logic        mreq;
        logic        wr;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic fm;
        logic oki;
        logic bank;
        logic oki7;
        logic latch0;
        logic latch1;
    } dev_sel_t;

    // ADPCM command byte, top bit tells the two apart
    typedef union packed {
        struct packed {
            logic       start;
            logic [6:0] phrase;
        } play;
        struct packed {
            logic       zero;
            logic [6:0] ignored;
        } stop;
    } adpcm_cmd_u;

    localparam logic [3:0] IO_PAGE  = 4'hF;
    localparam logic [3:0] RAM_PAGE = 4'hD;

    localparam logic [9:0] FM_CEN_N  = 10'd3;   // 3.6 MHz
    localparam logic [9:0] FM_CEN_M  = 10'd40;
    localparam logic [9:0] OKI_CEN_N = 10'd1;   // 1 MHz
    localparam logic [9:0] OKI_CEN_M = 10'd48;

    localparam logic [7:0] ADPCM_DIV_FAST  = 8'd132;
    localparam logic [7:0] ADPCM_DIV_SLOW  = 8'd165;
    localparam logic [7:0] ADPCM_STOP_BYTE = 8'h80;

    localparam logic [10:0] STEP_TABLE [49] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    localparam logic signed [4:0] INDEX_ADJ [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
    };

endpackage
